// ==== sim/rgb_vectors.txt ====
# rwin gwin bwin tol pix0 pix1 bad pass, all hex; win is hi:lo, pix is rrggbb
# pix0 is slot 0 (low half), pix1 slot 1, each held for the whole frame
FF00 FF00 FF00 0000 102030 405060 0000 1
8020 FF00 FF00 0000 903030 903030 0040 0
FF00 8020 FF00 0040 301030 301030 0040 1
FF00 FF00 8020 003F 3030F0 3030F0 0040 0
8020 8020 8020 0020 202020 808080 0000 1
8020 8020 8020 0020 1F2020 808080 0020 1
8020 8020 8020 001F 1F2020 808080 0020 0
8020 8020 8020 0010 202020 808180 0020 0
8020 8020 8020 0000 50501F 505081 0040 0
6040 A080 4010 0000 509020 3F9020 0020 0
6040 A080 4010 0020 60A040 40A141 0020 1
6040 A080 4010 0000 408010 40800F 0020 0
FF00 FF00 FF00 0000 123456 ABCDEF 0000 1
FF00 FF00 FF00 0000 123456 ABCDEF 0000 1
FF00 FF00 FF00 0000 FFFFFF 000000 0000 1

// ==== vlog.f ====
rtl/pix_pkg.sv
rtl/video_timing_gen.sv
rtl/pixel_window_check.sv
rtl/frame_crc.sv
rtl/analyze_regs.sv
rtl/rgb_analyze_top.sv
sim/rgb_analyze_sva.sv
sim/tb_rgb_analyze.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rgb_analyze
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Verdict comes from the log, not from the exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_rgb_analyze.sv ====
`timescale 1ns/10ps

module tb_rgb_analyze;
    import pix_pkg::*;

    localparam int clk_period  = 8;
    localparam int frame_words = h_active * v_active;     // 32 words of 2 pixels
    localparam int irq_timeout = 3 * h_total * v_total;   // Three frames in clocks
    localparam int rdy_timeout = 16;

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic [pix_w-1:0]  pix;
    logic              de;
    logic              hs;
    logic              vs;
    logic              irq;

    logic [31:0] crc_table [256];   // Byte table for MSB first CRC
    int          errors;
    int          checks;
    int          tests;

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    rgb_analyze_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .pix     (pix),
        .de      (de),
        .hs      (hs),
        .vs      (vs),
        .irq     (irq)
    );

    //////////////////////////////
    // Reference CRC-32 without reflection
    //////////////////////////////
    function automatic void fill_crc_table();
        logic [31:0] t;
        for (int i = 0; i < 256; i++) begin
            t = {8'(i), 24'h0};
            for (int j = 0; j < 8; j++) begin
                t = t[31] ? ({t[30:0], 1'b0} ^ crc_poly) : {t[30:0], 1'b0};
            end
            crc_table[i] = t;
        end
    endfunction

    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
        return {c[23:0], 8'h00} ^ crc_table[c[31:24] ^ b];
    endfunction

    // Frame of one repeated word in byte order r1 g1 b1 r0 g0 b0
    function automatic logic [31:0] frame_crc_ref(input logic [pix_w-1:0] word);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;                       // All ones seed and no final xor
        for (int w = 0; w < frame_words; w++) begin
            for (int k = pix_w / 8 - 1; k >= 0; k--) begin
                c = crc_byte(c, word[k*8 +: 8]);
            end
        end
        return c;
    endfunction

    //////////////////////////////
    // Checking and reporting
    //////////////////////////////
    task automatic abort_run(input string why);
        $display("ERROR: %s (at %0t ns)", why, $time);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d error(s)", name, errors - err_before);
    endtask

    //////////////////////////////
    // APB master
    //////////////////////////////
    task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waits;
        @(posedge clk);
        #1;
        psel    = 1'b1;                          // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;                          // Access phase
        #3;                                      // Sample mid cycle
        waits = 0;
        while (!pready && waits < rdy_timeout) begin
            @(posedge clk);
            #4;
            waits++;
        end
        if (!pready) begin
            abort_run("APB slave never raised pready");
        end else begin
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);
            #1;
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        bus_access(1'b1, addr, data, rd, err);
        expect_eq($sformatf("pslverr (write %h)", addr), 32'(err), 32'h0);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        bus_access(1'b0, addr, 32'h0, data, err);
        expect_eq($sformatf("pslverr (read %h)", addr), 32'(err), 32'h0);
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        read_reg(addr, rd);
        expect_eq($sformatf("prdata (reg %h)", addr), rd, exp);
    endtask

    // Hole in the map must answer with pslverr
    task automatic check_unmapped(input logic wr, input logic [7:0] addr);
        logic [31:0] rd;
        logic        err;
        bus_access(wr, addr, 32'hFFFF_FFFF, rd, err);
        expect_eq($sformatf("pslverr (unmapped %h)", addr), 32'(err), 32'h1);
    endtask

    task automatic wait_irq();
        int cycles;
        cycles = 0;
        while (irq !== 1'b1 && cycles < irq_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (irq !== 1'b1)
            abort_run("irq did not rise within the frame timeout");
    endtask

    //////////////////////////////
    // One vector, two frames
    //////////////////////////////
    // First frame may straddle the new settings and only the second is checked
    task automatic run_vector(input int idx, input logic [15:0] rwin, input logic [15:0] gwin,
                              input logic [15:0] bwin, input logic [15:0] tol,
                              input logic [23:0] p0, input logic [23:0] p1,
                              input logic [15:0] exp_bad, input logic exp_pass);
        logic [31:0] rd;
        logic [7:0]  fn;
        int          err_before;
        err_before = errors;
        pix = {p1, p0};                          // Slot 0 in low half
        write_reg(reg_rwin, {16'h0, rwin});
        write_reg(reg_gwin, {16'h0, gwin});
        write_reg(reg_bwin, {16'h0, bwin});
        write_reg(reg_tol, {16'h0, tol});
        write_reg(reg_status, 32'h1);            // Drop any frame done during setup
        wait_irq();
        read_reg(reg_status, rd);
        fn = rd[15:8];
        write_reg(reg_status, 32'h1);
        expect_eq("irq after clear", 32'(irq), 32'h0);
        wait_irq();                              // Clean frame
        check_reg(reg_bad, {16'h0, exp_bad});
        check_reg(reg_status, {16'h0, 8'(fn + 8'd1), 6'h0, exp_pass, 1'b1});
        check_reg(reg_crc, frame_crc_ref({p1, p0}));
        write_reg(reg_status, 32'h1);
        report_test($sformatf("vector %0d (bad %0d, pass %0d)", idx, exp_bad, exp_pass),
                    err_before);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int          fd;
        int          n;
        int          vec;
        int          err_before;
        string       line;
        logic [31:0] crc;
        logic [15:0] rwin;
        logic [15:0] gwin;
        logic [15:0] bwin;
        logic [15:0] tol;
        logic [23:0] p0;
        logic [23:0] p1;
        logic [15:0] exp_bad;
        logic        exp_pass;

        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pix     = '0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        vec     = 0;
        fill_crc_table();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset values and map holes
        err_before = errors;
        expect_eq("de", 32'(de), 32'h0);
        expect_eq("hs", 32'(hs), 32'h0);
        expect_eq("vs", 32'(vs), 32'h0);
        expect_eq("irq", 32'(irq), 32'h0);
        check_reg(reg_ctrl, 32'h0);
        check_reg(reg_rwin, 32'h0000_FF00);      // Windows open
        check_reg(reg_gwin, 32'h0000_FF00);
        check_reg(reg_bwin, 32'h0000_FF00);
        check_reg(reg_tol, 32'h0);
        check_reg(reg_status, 32'h0);
        check_reg(reg_bad, 32'h0);
        check_reg(reg_crc, 32'h0);
        check_unmapped(1'b0, 8'h02);
        check_unmapped(1'b0, 8'h20);
        check_unmapped(1'b1, 8'hFC);
        report_test("reset state", err_before);

        // Model against the CRC-32/MPEG-2 check string
        err_before = errors;
        crc = 32'hFFFF_FFFF;
        for (int i = 1; i <= 9; i++) begin
            crc = crc_byte(crc, 8'h30 + 8'(i));
        end
        expect_eq("reference crc of 123456789", crc, 32'h0376_E6E7);
        report_test("crc model check value", err_before);

        write_reg(reg_ctrl, 32'h1);              // Raster runs from here on
        fd = $fopen("sim/rgb_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open sim/rgb_vectors.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            rwin, gwin, bwin, tol, p0, p1, exp_bad, exp_pass);
                if (n == 8) begin             // Comment lines do not parse
                    vec++;
                    run_vector(vec, rwin, gwin, bwin, tol, p0, p1, exp_bad, exp_pass);
                end
            end
            $fclose(fd);
            if (vec == 0) begin
                errors++;
                $display("ERROR: no vectors found in sim/rgb_vectors.txt");
            end
            if (UUT.u_regs.u_sva.fail_count != 0) begin
                errors = errors + UUT.u_regs.u_sva.fail_count;
                $display("ERROR: %0d bound assertion failure(s) in the register block",
                         UUT.u_regs.u_sva.fail_count);
            end
            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            if (errors == 0)
                $display("TEST OK");
            else
                $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// ==== sim/rgb_analyze_sva.sv ====
`timescale 1ns/10ps

module rgb_analyze_sva (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       psel,
    input logic                       penable,
    input logic                       pwrite,
    input logic [pix_pkg::addr_w-1:0] paddr,
    input logic [pix_pkg::data_w-1:0] pwdata,
    input logic                       irq,
    input logic                       done,
    input logic                       res_valid,
    input logic [7:0]                 frame_no
);
    import pix_pkg::*;

    int   fail_count;    // Failed assertions so far
    logic status_clr;    // W1C access to the done bit

    initial fail_count = 0;

    assign status_clr = psel && penable && pwrite && (paddr == reg_status) && pwdata[0];

    // Irq stays up until software acks it
    a_irq_clear: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(irq) |-> $past(status_clr))
        else begin
            fail_count++;
            $error("irq fell without a status write of 1");
        end

    //////////////////////////////
    // Frame end
    //////////////////////////////
    // Done only sets from a latched frame result
    a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(res_valid))
        else begin
            fail_count++;
            $error("done rose without res_valid in the cycle before");
        end

    // One count per frame result
    a_frame_step: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |=> (frame_no == $past(frame_no) + 8'd1))
        else begin
            fail_count++;
            $error("frame number did not step by one after res_valid");
        end

endmodule

bind analyze_regs rgb_analyze_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .irq       (irq),
    .done      (done),
    .res_valid (res_valid),
    .frame_no  (frame_no)
);

// ==== rtl/rgb_analyze_top.sv ====
`timescale 1ns/10ps

module rgb_analyze_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [pix_pkg::addr_w-1:0] paddr,
    input  logic [pix_pkg::data_w-1:0] pwdata,
    output logic [pix_pkg::data_w-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic [pix_pkg::pix_w-1:0]  pix,     // Sampled with de
    output logic                       de,
    output logic                       hs,
    output logic                       vs,
    output logic                       irq
);
    import pix_pkg::*;

    logic             run;
    logic             frame_end;
    logic             res_valid;
    logic [cnt_w-1:0] bad_count;
    logic [31:0]      crc;
    logic [7:0]       r_lo, r_hi;
    logic [7:0]       g_lo, g_hi;
    logic [7:0]       b_lo, b_hi;

    //////////////////////////////
    // Raster timing
    //////////////////////////////
    video_timing_gen u_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .de        (de),
        .hs        (hs),
        .vs        (vs),
        .frame_end (frame_end)
    );

    //////////////////////////////
    // Analysis datapath
    //////////////////////////////
    pixel_window_check u_check (
        .clk       (clk),
        .rst_n     (rst_n),
        .de        (de),
        .frame_end (frame_end),
        .pix       (pix),
        .r_lo      (r_lo),
        .r_hi      (r_hi),
        .g_lo      (g_lo),
        .g_hi      (g_hi),
        .b_lo      (b_lo),
        .b_hi      (b_hi),
        .bad_count (bad_count),
        .res_valid (res_valid)   // Also strobes CRC into regs
    );

    frame_crc u_crc (
        .clk       (clk),
        .rst_n     (rst_n),
        .de        (de),
        .frame_end (frame_end),
        .pix       (pix),
        .crc       (crc)
    );

    // APB register block
    analyze_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .bad_count (bad_count),
        .crc       (crc),
        .res_valid (res_valid),
        .run       (run),
        .r_lo      (r_lo),
        .r_hi      (r_hi),
        .g_lo      (g_lo),
        .g_hi      (g_hi),
        .b_lo      (b_lo),
        .b_hi      (b_hi),
        .irq       (irq)
    );

endmodule

// ==== rtl/analyze_regs.sv ====
`timescale 1ns/10ps

module analyze_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    // APB slave
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [pix_pkg::addr_w-1:0] paddr,
    input  logic [pix_pkg::data_w-1:0] pwdata,
    output logic [pix_pkg::data_w-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    // Frame results
    input  logic [pix_pkg::cnt_w-1:0]  bad_count,
    input  logic [31:0]                crc,
    input  logic                       res_valid,
    // Control
    output logic                       run,
    output logic [7:0]                 r_lo,
    output logic [7:0]                 r_hi,
    output logic [7:0]                 g_lo,
    output logic [7:0]                 g_hi,
    output logic [7:0]                 b_lo,
    output logic [7:0]                 b_hi,
    output logic                       irq
);
    import pix_pkg::*;

    logic             wr_en;      // Access phase write
    logic             addr_hit;   // Mapped offset
    logic [cnt_w-1:0] tol;
    logic             done;       // Sticky, W1C
    logic             pass;
    logic [7:0]       frame_no;
    logic [cnt_w-1:0] bad_q;
    logic [31:0]      crc_q;

    assign pready = 1'b1;         // Zero wait states
    assign wr_en  = psel && penable && pwrite;

    //////////////////////////////
    // Control registers
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run  <= 1'b0;
            r_lo <= 8'h00;  r_hi <= 8'hFF;   // Windows fully open
            g_lo <= 8'h00;  g_hi <= 8'hFF;
            b_lo <= 8'h00;  b_hi <= 8'hFF;
            tol  <= '0;
        end else if (wr_en) begin
            case (paddr)
                reg_ctrl: run <= pwdata[0];
                reg_rwin: {r_hi, r_lo} <= pwdata[15:0];
                reg_gwin: {g_hi, g_lo} <= pwdata[15:0];
                reg_bwin: {b_hi, b_lo} <= pwdata[15:0];
                reg_tol:  tol <= pwdata[cnt_w-1:0];
                default: ;                   // Results are read only
            endcase
        end
    end

    //////////////////////////////
    // Results and status
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done     <= 1'b0;
            pass     <= 1'b0;
            frame_no <= '0;
            bad_q    <= '0;
            crc_q    <= '0;
        end else if (res_valid) begin
            // New frame overrides any clear in the same cycle
            done     <= 1'b1;
            pass     <= (bad_count <= tol);
            frame_no <= frame_no + 1'b1;
            bad_q    <= bad_count;
            crc_q    <= crc;
        end else if (wr_en && (paddr == reg_status) && pwdata[0]) begin
            done <= 1'b0;                    // Ack clears irq
        end
    end

    assign irq = done;

    //////////////////////////////
    // Read decode
    //////////////////////////////
    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            reg_ctrl:   prdata = {{(data_w-1){1'b0}}, run};
            reg_rwin:   prdata = {16'h0, r_hi, r_lo};
            reg_gwin:   prdata = {16'h0, g_hi, g_lo};
            reg_bwin:   prdata = {16'h0, b_hi, b_lo};
            reg_tol:    prdata = {{(data_w-cnt_w){1'b0}}, tol};
            reg_status: prdata = {16'h0, frame_no, 6'h0, pass, done};
            reg_bad:    prdata = {{(data_w-cnt_w){1'b0}}, bad_q};
            reg_crc:    prdata = crc_q;
            default:    addr_hit = 1'b0;     // Hole in the map
        endcase
    end

    // Error only in access phase, reads and writes alike
    assign pslverr = psel && penable && !addr_hit;

endmodule

// ==== rtl/frame_crc.sv ====
`timescale 1ns/10ps

module frame_crc (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     de,
    input  logic                     frame_end,
    input  logic [pix_pkg::pix_w-1:0] pix,
    output logic [31:0]              crc        // Last frame's CRC
);
    import pix_pkg::*;

    logic [31:0] crc_run;    // Running CRC of current frame
    logic [31:0] crc_next;

    // Bitwise CRC-32 over one pixel word, MSB first
    function automatic logic [31:0] crc_fold(
        input logic [31:0]      crc_in,
        input logic [pix_w-1:0] data
    );
        logic [31:0] c;
        logic        fb;
        c = crc_in;
        for (int i = pix_w - 1; i >= 0; i--) begin
            fb = c[31] ^ data[i];
            c  = {c[30:0], 1'b0} ^ (fb ? crc_poly : 32'h0);
        end
        return c;
    endfunction

    assign crc_next = crc_fold(crc_run, pix);

    //////////////////////////////
    // Running CRC
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_run <= crc_seed;
        end else if (frame_end) begin
            crc_run <= crc_seed;          // Reseed for next frame
        end else if (de) begin
            crc_run <= crc_next;
        end
    end

    // Latched result, no final inversion
    always_ff @(posedge clk) begin
        if (frame_end)
            crc <= crc_run;
    end

endmodule

// ==== rtl/pixel_window_check.sv ====
`timescale 1ns/10ps

module pixel_window_check (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     de,
    input  logic                     frame_end,
    input  logic [pix_pkg::pix_w-1:0] pix,
    input  logic [7:0]               r_lo,
    input  logic [7:0]               r_hi,
    input  logic [7:0]               g_lo,
    input  logic [7:0]               g_hi,
    input  logic [7:0]               b_lo,
    input  logic [7:0]               b_hi,
    output logic [pix_pkg::cnt_w-1:0] bad_count,   // Last frame's count
    output logic                     res_valid     // Frame end + 1
);
    import pix_pkg::*;

    logic [bpc-1:0]   comp_r [pix_per_clk];
    logic [bpc-1:0]   comp_g [pix_per_clk];
    logic [bpc-1:0]   comp_b [pix_per_clk];
    logic             bad_pix [pix_per_clk];   // Pixel fails any window
    logic [cnt_w-1:0] bad_inc;                 // Failing pixels this clock
    logic [cnt_w-1:0] run_cnt;                 // Count so far this frame

    //////////////////////////////
    // Window compare
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < pix_per_clk; i++) begin
            // Blue in low bits, red on top
            comp_b[i] = pix[i*3*bpc           +: bpc];
            comp_g[i] = pix[i*3*bpc + bpc     +: bpc];
            comp_r[i] = pix[i*3*bpc + 2*bpc   +: bpc];

            // Inclusive limits, lo and hi themselves pass
            bad_pix[i] = (comp_r[i] < r_lo) || (comp_r[i] > r_hi)
                      || (comp_g[i] < g_lo) || (comp_g[i] > g_hi)
                      || (comp_b[i] < b_lo) || (comp_b[i] > b_hi);
        end
    end

    // Population count of failing slots
    always_comb begin
        bad_inc = '0;
        for (int i = 0; i < pix_per_clk; i++) begin
            bad_inc = bad_inc + cnt_w'(bad_pix[i]);
        end
    end

    //////////////////////////////
    // Frame accumulation
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_cnt   <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= frame_end;        // Result ready next cycle
            if (frame_end)
                run_cnt <= '0;             // Restart for next frame
            else if (de)
                run_cnt <= run_cnt + bad_inc;
        end
    end

    // Frame result, only loaded at frame end
    always_ff @(posedge clk) begin
        if (frame_end)
            bad_count <= run_cnt;
    end

endmodule

// ==== rtl/video_timing_gen.sv ====
`timescale 1ns/10ps

module video_timing_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic run,        // Low holds raster at origin
    output logic de,
    output logic hs,
    output logic vs,
    output logic frame_end   // Last clock of last line
);
    import pix_pkg::*;

    logic [hcnt_w-1:0] h_cnt;   // Clock within line
    logic [vcnt_w-1:0] v_cnt;   // Line within frame
    logic              h_last;
    logic              v_last;

    assign h_last = (h_cnt == hcnt_w'(h_total - 1));
    assign v_last = (v_cnt == vcnt_w'(v_total - 1));

    //////////////////////////////
    // Raster counters
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!run) begin
            // Stopped, park at first active pixel
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last)
                v_cnt <= '0;            // Wrap to next frame
            else
                v_cnt <= v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Strobes
    //////////////////////////////
    // Active region sits at the start of each line and frame
    assign de = run
             && (h_cnt < hcnt_w'(h_active))
             && (v_cnt < vcnt_w'(v_active));

    // Sync pulses open the blanking intervals
    assign hs = run
             && (h_cnt >= hcnt_w'(h_active))
             && (h_cnt <  hcnt_w'(h_active + hs_width));

    assign vs = run
             && (v_cnt >= vcnt_w'(v_active))
             && (v_cnt <  vcnt_w'(v_active + vs_width));

    // Single cycle, falls in vertical blanking
    assign frame_end = run && h_last && v_last;

endmodule

// ==== rtl/pix_pkg.sv ====
package pix_pkg;

    //////////////////////////////
    // Pixel bus
    //////////////////////////////
    localparam int pix_per_clk = 2;                       // Pixels per clock
    localparam int bpc         = 8;                       // Bits per component
    localparam int pix_w       = pix_per_clk * 3 * bpc;   // 48 bit pixel word

    //////////////////////////////
    // Raster, clocks and lines
    //////////////////////////////
    localparam int h_active = 8;     // 8 clocks x 2 pixels = 16 px
    localparam int h_total  = 12;
    localparam int v_active = 4;
    localparam int v_total  = 6;
    localparam int hs_width = 2;     // Clocks
    localparam int vs_width = 1;     // Lines
    localparam int hcnt_w   = $clog2(h_total);
    localparam int vcnt_w   = $clog2(v_total);

    // Bad pixel counter and tolerance
    localparam int cnt_w = 16;

    // CRC-32, MSB first, seed all ones, no final xor
    localparam logic [31:0] crc_poly = 32'h04C11DB7;
    localparam logic [31:0] crc_seed = 32'hFFFF_FFFF;

    //////////////////////////////
    // APB and register map
    //////////////////////////////
    localparam int addr_w = 8;
    localparam int data_w = 32;

    localparam logic [addr_w-1:0] reg_ctrl   = 8'h00;  // Bit 0 run
    localparam logic [addr_w-1:0] reg_rwin   = 8'h04;  // Hi 15:8, lo 7:0
    localparam logic [addr_w-1:0] reg_gwin   = 8'h08;
    localparam logic [addr_w-1:0] reg_bwin   = 8'h0C;
    localparam logic [addr_w-1:0] reg_tol    = 8'h10;
    localparam logic [addr_w-1:0] reg_status = 8'h14;  // Frame no, pass, done
    localparam logic [addr_w-1:0] reg_bad    = 8'h18;
    localparam logic [addr_w-1:0] reg_crc    = 8'h1C;

endpackage
